// ==== sim.f ====
+incdir+.
icache_pkg.sv
icache_lookup.sv
icache_refill.sv
apb_arbiter.sv
backing_mem.sv
icache_subsys.sv
icache_props.sv
icache_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction cache testbench

TOP = icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== icache_tb.sv ====
// testbench for the instruction cache subsystem
// fetches stay inside the first 256 words, host-only traffic sits above word 511
// memory words are undefined until the host port writes them
`include "icache_settings.svh"

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import icache_pkg::*;

  localparam int depth = 1 << `ICACHE_LOG2_DEPTH;
  localparam int line_words = 1 << `ICACHE_LOG2_LINE_WORDS;
  localparam int mem_words = 1 << `MEM_LOG2_WORDS;
  localparam int fetch_words = 256;
  localparam int wait_limit = 200;

  logic bus_clk;
  logic resetn;
  logic [31:0] bus_address;
  logic bus_en;
  logic bus_flush;
  apb_req_t host_req;
  logic [31:0] bus_readdata;
  logic bus_wait;
  logic cache_hit;
  logic cache_miss;
  logic flush_busy;
  apb_rsp_t host_rsp;

  // memory mirror and a shadow of the cache contents
  logic [31:0] mem_model [mem_words];
  logic sh_valid [depth];
  logic [`ICACHE_TAG_BITS-1:0] sh_tag [depth];
  logic [line_words-1:0][31:0] sh_line [depth];

  logic [31:0] stale_addrs [$];
  logic [31:0] host_addrs [$];
  logic [31:0] addr;
  logic [31:0] pair_a;

  icache_subsys u_icache_subsys (
    .bus_clk      (bus_clk),
    .resetn       (resetn),
    .bus_address  (bus_address),
    .bus_en       (bus_en),
    .bus_flush    (bus_flush),
    .host_req     (host_req),
    .bus_readdata (bus_readdata),
    .bus_wait     (bus_wait),
    .cache_hit    (cache_hit),
    .cache_miss   (cache_miss),
    .flush_busy   (flush_busy),
    .host_rsp     (host_rsp)
  );

  always #50 bus_clk = ~bus_clk;

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL time=%0t %s expected=%h got=%h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // bound property failures stop the run
  always @(negedge bus_clk) begin
    assert (u_icache_subsys.u_props.fail_count == 0) else begin
      $display("a concurrent property on the DUT failed at %0t", $time);
      abort_run();
    end
  end

  function automatic int mem_index(input logic [31:0] a);
    return int'(a[2 +: `MEM_LOG2_WORDS]);
  endfunction

  function automatic logic [31:0] random_fetch_addr();
    return 32'(($urandom() % fetch_words) * 4);
  endfunction

  // one fetch, held until bus_wait drops
  task automatic fetch_check(input logic [31:0] a);
    int idx;
    int base;
    int cycles;
    logic exp_hit;
    logic [31:0] exp_data;
    idx = int'(a[`ICACHE_LOG2_LINE_WORDS + 2 +: `ICACHE_LOG2_DEPTH]);
    exp_hit = sh_valid[idx] && (sh_tag[idx] == a[31 -: `ICACHE_TAG_BITS]);
    if (!exp_hit) begin
      base = mem_index(a) & ~(line_words - 1);
      sh_valid[idx] = 1'b1;
      sh_tag[idx] = a[31 -: `ICACHE_TAG_BITS];
      for (int w = 0; w < line_words; w++) begin
        sh_line[idx][w] = mem_model[base + w];
      end
    end
    exp_data = sh_line[idx][a[2 +: `ICACHE_LOG2_LINE_WORDS]];
    @(negedge bus_clk);
    bus_address = a;
    bus_en = 1'b1;
    @(negedge bus_clk);
    // in the answer cycle a cached line hits and a new line misses
    if (exp_hit) begin
      check_value("bus_wait", bus_wait, 32'd0);
      check_value("cache_hit", cache_hit, 32'd1);
    end else begin
      check_value("cache_miss", cache_miss, 32'd1);
    end
    cycles = 0;
    while (bus_wait) begin
      if (cycles >= wait_limit) begin
        report_timeout("a cache refill");
      end
      @(negedge bus_clk);
      cycles++;
    end
    check_value("bus_readdata", bus_readdata, exp_data);
    bus_en = 1'b0;
  endtask

  task automatic host_xfer(input logic wr, input logic [31:0] a,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    @(negedge bus_clk);
    host_req.psel = 1'b1;
    host_req.penable = 1'b0;
    host_req.pwrite = wr;
    host_req.paddr = a;
    host_req.pwdata = wdata;
    @(negedge bus_clk);
    host_req.penable = 1'b1;
    cycles = 0;
    do begin
      if (cycles >= wait_limit) begin
        report_timeout("pready on the host port");
      end
      @(negedge bus_clk);
      cycles++;
    end while (!host_rsp.pready);
    rdata = host_rsp.prdata;
    // transfer completes on the next rising edge
    @(negedge bus_clk);
    host_req = '0;
  endtask

  task automatic host_write(input logic [31:0] a, input logic [31:0] data);
    logic [31:0] unused;
    host_xfer(1'b1, a, data, unused);
    mem_model[mem_index(a)] = data;
  endtask

  task automatic host_read_check(input logic [31:0] a);
    logic [31:0] rd;
    host_xfer(1'b0, a, 32'd0, rd);
    check_value("host_rsp.prdata", rd, mem_model[mem_index(a)]);
  endtask

  task automatic flush_cache();
    int cycles;
    @(negedge bus_clk);
    bus_flush = 1'b1;
    @(negedge bus_clk);
    bus_flush = 1'b0;
    check_value("flush_busy", flush_busy, 32'd1);
    cycles = 0;
    while (flush_busy) begin
      if (cycles >= wait_limit) begin
        report_timeout("the flush walk");
      end
      @(negedge bus_clk);
      cycles++;
    end
    for (int i = 0; i < depth; i++) begin
      sh_valid[i] = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(58));
    bus_clk = 1'b0;
    resetn = 1'b0;
    bus_address = '0;
    bus_en = 1'b0;
    bus_flush = 1'b0;
    host_req = '0;
    for (int i = 0; i < depth; i++) begin
      sh_valid[i] = 1'b0;
    end
    repeat (16) @(posedge bus_clk);
    @(negedge bus_clk);
    resetn = 1'b1;
    @(negedge bus_clk);
    check_value("bus_wait", bus_wait, 32'd0);
    check_value("cache_hit", cache_hit, 32'd0);
    check_value("cache_miss", cache_miss, 32'd0);
    check_value("flush_busy", flush_busy, 32'd0);
    check_value("host_rsp.pready", host_rsp.pready, 32'd0);

    // load a program image, then random fetches
    for (int i = 0; i < fetch_words; i++) begin
      host_write(32'(i * 4), $urandom());
    end
    flush_cache();
    repeat (60) fetch_check(random_fetch_addr());

    // same index, two tags, fetched in turn
    pair_a = random_fetch_addr() & 32'h0000_00fc;
    repeat (4) begin
      fetch_check(pair_a);
      fetch_check(pair_a + 32'h100);
    end

    // rewrites without a flush stay invisible until the next flush
    repeat (6) begin
      addr = random_fetch_addr();
      fetch_check(addr);
      host_write(addr, ~mem_model[mem_index(addr)]);
      fetch_check(addr);
      stale_addrs.push_back(addr);
    end
    flush_cache();
    foreach (stale_addrs[i]) begin
      fetch_check(stale_addrs[i]);
    end

    // host traffic competing with refills
    flush_cache();
    fork
      begin
        repeat (40) fetch_check(random_fetch_addr());
      end
      begin
        repeat (48) begin
          addr = 32'((512 + ($urandom() % 512)) * 4);
          host_write(addr, $urandom());
          host_addrs.push_back(addr);
        end
      end
    join
    foreach (host_addrs[i]) begin
      host_read_check(host_addrs[i]);
    end

    if (u_icache_subsys.u_props.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("a concurrent property on the DUT failed");
      abort_run();
    end
  end

endmodule

// ==== icache_props.sv ====
// concurrent checks on the shared APB, the fill bus and the fetch status outputs
// expects the top level to name its memory request mem_req and its fill bus fill
module icache_props (
  input logic                 bus_clk,
  input logic                 resetn,
  input icache_pkg::apb_req_t mem_req,
  input icache_pkg::fill_t    fill,
  input logic                 bus_en,
  input logic                 bus_wait,
  input logic                 cache_hit,
  input logic                 flush_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  // count of failed properties
  int unsigned fail_count = 0;

  // every access phase at the memory follows a setup cycle
  penable_after_setup: assert property (
    @(posedge bus_clk) disable iff (!resetn)
    $rose(mem_req.penable) |-> $past(mem_req.psel && !mem_req.penable)
  ) else begin
    fail_count++;
    $error("memory access phase without a setup cycle");
  end

  // no hit during a walk, nor in the cycle after it when every valid bit is clear
  no_hit_in_flush: assert property (
    @(posedge bus_clk) disable iff (!resetn)
    !(cache_hit && (flush_busy || $past(flush_busy)))
  ) else begin
    fail_count++;
    $error("hit reported during or right after a flush walk");
  end

  // a fill for the held fetch lets it hit on the next lookup cycle
  fill_then_hit: assert property (
    @(posedge bus_clk) disable iff (!resetn)
    (fill.we && !flush_busy && bus_en) |=> (!bus_wait || flush_busy)
  ) else begin
    fail_count++;
    $error("held fetch still waits after its line was filled");
  end

endmodule

bind icache_subsys icache_props u_props (
  .bus_clk    (bus_clk),
  .resetn     (resetn),
  .mem_req    (mem_req),
  .fill       (fill),
  .bus_en     (bus_en),
  .bus_wait   (bus_wait),
  .cache_hit  (cache_hit),
  .flush_busy (flush_busy)
);

// ==== icache_subsys.sv ====
// instruction cache with APB refill from a shared backing memory
// host writes do not touch cached lines, flush after loading code
module icache_subsys (
  input  logic                 bus_clk,
  input  logic                 resetn,
  input  logic [31:0]          bus_address,
  input  logic                 bus_en,
  input  logic                 bus_flush,
  input  icache_pkg::apb_req_t host_req,
  output logic [31:0]          bus_readdata,
  output logic                 bus_wait,
  output logic                 cache_hit,
  output logic                 cache_miss,
  output logic                 flush_busy,
  output icache_pkg::apb_rsp_t host_rsp
);

  import icache_pkg::*;

  logic miss_req;
  logic [31:0] miss_addr;
  fill_t fill;
  apb_req_t refill_req;
  apb_rsp_t refill_rsp;
  apb_req_t mem_req;
  apb_rsp_t mem_rsp;

  icache_lookup u_lookup (
    .bus_clk      (bus_clk),
    .resetn       (resetn),
    .bus_address  (bus_address),
    .bus_en       (bus_en),
    .flush        (bus_flush),
    .fill         (fill),
    .bus_readdata (bus_readdata),
    .bus_wait     (bus_wait),
    .cache_hit    (cache_hit),
    .cache_miss   (cache_miss),
    .flush_busy   (flush_busy),
    .miss_req     (miss_req),
    .miss_addr    (miss_addr)
  );

  icache_refill u_refill (
    .bus_clk   (bus_clk),
    .resetn    (resetn),
    .miss_req  (miss_req),
    .miss_addr (miss_addr),
    .mem_rsp   (refill_rsp),
    .mem_req   (refill_req),
    .fill      (fill)
  );

  apb_arbiter u_arbiter (
    .bus_clk    (bus_clk),
    .resetn     (resetn),
    .refill_req (refill_req),
    .host_req   (host_req),
    .mem_rsp    (mem_rsp),
    .refill_rsp (refill_rsp),
    .host_rsp   (host_rsp),
    .mem_req    (mem_req)
  );

  backing_mem u_mem (
    .bus_clk (bus_clk),
    .resetn  (resetn),
    .req     (mem_req),
    .rsp     (mem_rsp)
  );

endmodule

// ==== backing_mem.sv ====
// APB word memory, one wait cycle in every access phase
// address bits above the array size are ignored, so the space aliases
// contents are undefined until written
`include "icache_settings.svh"

module backing_mem (
  input  logic                 bus_clk,
  input  logic                 resetn,
  input  icache_pkg::apb_req_t req,
  output icache_pkg::apb_rsp_t rsp
);

  logic [31:0] mem [1 << `MEM_LOG2_WORDS];
  logic [`MEM_LOG2_WORDS-1:0] word_addr;
  logic rdy_q;

  assign word_addr = req.paddr[2 +: `MEM_LOG2_WORDS];

  // first access cycle waits, the second one is ready
  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= req.psel && req.penable && !rdy_q;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (req.psel && req.penable && rdy_q && req.pwrite) begin
      mem[word_addr] <= req.pwdata;
    end
  end

  assign rsp.pready = rdy_q;
  assign rsp.prdata = mem[word_addr];

endmodule

// ==== apb_arbiter.sv ====
// two requesters onto one APB slave, round robin when both wait
// the grant cycle is shown to the slave as a setup cycle, so a requester
// already in its access phase still gives the slave a proper setup
module apb_arbiter (
  input  logic                 bus_clk,
  input  logic                 resetn,
  input  icache_pkg::apb_req_t refill_req,
  input  icache_pkg::apb_req_t host_req,
  input  icache_pkg::apb_rsp_t mem_rsp,
  output icache_pkg::apb_rsp_t refill_rsp,
  output icache_pkg::apb_rsp_t host_rsp,
  output icache_pkg::apb_req_t mem_req
);

  import icache_pkg::*;

  arb_owner_e owner;
  arb_owner_e grant;
  arb_owner_e active;
  logic last_host;
  logic xfer_done;

  // new grant only from idle
  always_comb begin
    grant = owner_none;
    if (owner == owner_none) begin
      if (refill_req.psel && host_req.psel) begin
        grant = last_host ? owner_refill : owner_host;
      end else if (refill_req.psel) begin
        grant = owner_refill;
      end else if (host_req.psel) begin
        grant = owner_host;
      end
    end
  end

  assign active = (owner == owner_none) ? grant : owner;

  always_comb begin
    case (active)
      owner_refill: mem_req = refill_req;
      owner_host:   mem_req = host_req;
      default:      mem_req = '0;
    endcase
    if (owner == owner_none) begin
      mem_req.penable = 1'b0;
    end
  end

  assign xfer_done = mem_req.psel && mem_req.penable && mem_rsp.pready;

  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      owner     <= owner_none;
      last_host <= 1'b0;
    end else if (owner == owner_none) begin
      if (grant != owner_none) begin
        owner     <= grant;
        last_host <= (grant == owner_host);
      end
    end else if (xfer_done) begin
      owner <= owner_none;
    end
  end

  // response goes back to the owner only
  assign refill_rsp.pready = (owner == owner_refill) && mem_rsp.pready;
  assign refill_rsp.prdata = (owner == owner_refill) ? mem_rsp.prdata : '0;
  assign host_rsp.pready   = (owner == owner_host) && mem_rsp.pready;
  assign host_rsp.prdata   = (owner == owner_host) ? mem_rsp.prdata : '0;

endmodule

// ==== icache_refill.sv ====
// reads one missing line over APB, word by word, then writes it back
// line address is taken only from idle, so a held miss_req is harmless
`include "icache_settings.svh"

module icache_refill (
  input  logic                 bus_clk,
  input  logic                 resetn,
  input  logic                 miss_req,
  input  logic [31:0]          miss_addr,
  input  icache_pkg::apb_rsp_t mem_rsp,
  output icache_pkg::apb_req_t mem_req,
  output icache_pkg::fill_t    fill
);

  import icache_pkg::*;

  localparam int line_words = 1 << `ICACHE_LOG2_LINE_WORDS;
  localparam int idx_lsb = `ICACHE_LOG2_LINE_WORDS + 2;

  refill_state_e state;
  logic [31:idx_lsb] line_addr;
  logic [`ICACHE_LOG2_LINE_WORDS-1:0] word_cnt;
  logic [line_words-1:0][31:0] line_q;

  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      state    <= refill_idle;
      word_cnt <= '0;
    end else begin
      case (state)
        refill_idle: begin
          if (miss_req) begin
            word_cnt <= '0;
            state    <= refill_setup;
          end
        end
        refill_setup: state <= refill_access;
        refill_access: begin
          if (mem_rsp.pready) begin
            if (&word_cnt) begin
              state <= refill_write;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              state    <= refill_setup;
            end
          end
        end
        default: state <= refill_idle;
      endcase
    end
  end

  // line address and collected words
  always_ff @(posedge bus_clk) begin
    if (state == refill_idle && miss_req) begin
      line_addr <= miss_addr[31:idx_lsb];
    end
    if (state == refill_access && mem_rsp.pready) begin
      line_q[word_cnt] <= mem_rsp.prdata;
    end
  end

  always_comb begin
    mem_req         = '0;
    mem_req.psel    = (state == refill_setup) || (state == refill_access);
    mem_req.penable = (state == refill_access);
    mem_req.paddr   = {line_addr, word_cnt, 2'b00};
  end

  always_comb begin
    fill.we    = (state == refill_write);
    fill.index = line_addr[idx_lsb +: `ICACHE_LOG2_DEPTH];
    fill.tag   = line_addr[31 -: `ICACHE_TAG_BITS];
    fill.line  = line_q;
  end

endmodule

// ==== icache_lookup.sv ====
// direct-mapped lookup, hit answered one cycle after the request edge
// CPU must hold bus_address and bus_en while bus_wait is high
// fills arriving during a flush walk are dropped
`include "icache_settings.svh"

module icache_lookup (
  input  logic                bus_clk,
  input  logic                resetn,
  input  logic [31:0]         bus_address,
  input  logic                bus_en,
  input  logic                flush,
  input  icache_pkg::fill_t   fill,
  output logic [31:0]         bus_readdata,
  output logic                bus_wait,
  output logic                cache_hit,
  output logic                cache_miss,
  output logic                flush_busy,
  output logic                miss_req,
  output logic [31:0]         miss_addr
);

  localparam int depth = 1 << `ICACHE_LOG2_DEPTH;
  localparam int line_words = 1 << `ICACHE_LOG2_LINE_WORDS;
  localparam int idx_lsb = `ICACHE_LOG2_LINE_WORDS + 2;

  // valid bits in flops so reset and the walker can clear them
  logic [depth-1:0] valid;
  logic [`ICACHE_TAG_BITS-1:0] tag_mem [depth];
  logic [line_words-1:0][31:0] data_mem [depth];

  logic [31:0] addr_q;
  logic en_q;
  logic [`ICACHE_LOG2_DEPTH-1:0] walk_cnt;

  logic [`ICACHE_LOG2_DEPTH-1:0] idx_q;
  logic [`ICACHE_LOG2_LINE_WORDS-1:0] word_q;
  logic [`ICACHE_TAG_BITS-1:0] tag_q;
  logic tag_match;

  // request address saved on every edge
  always_ff @(posedge bus_clk) begin
    addr_q <= bus_address;
  end

  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      en_q <= 1'b0;
    end else begin
      en_q <= bus_en;
    end
  end

  assign idx_q  = addr_q[idx_lsb +: `ICACHE_LOG2_DEPTH];
  assign word_q = addr_q[2 +: `ICACHE_LOG2_LINE_WORDS];
  assign tag_q  = addr_q[31 -: `ICACHE_TAG_BITS];

  // flush walker, one index per cycle
  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      flush_busy <= 1'b0;
      walk_cnt   <= '0;
    end else if (flush_busy) begin
      walk_cnt <= walk_cnt + 1'b1;
      if (&walk_cnt) begin
        flush_busy <= 1'b0;
      end
    end else if (flush) begin
      flush_busy <= 1'b1;
      walk_cnt   <= '0;
    end
  end

  always_ff @(posedge bus_clk or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
    end else if (flush_busy) begin
      valid[walk_cnt] <= 1'b0;
    end else if (fill.we) begin
      valid[fill.index] <= 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (fill.we && !flush_busy) begin
      tag_mem[fill.index]  <= fill.tag;
      data_mem[fill.index] <= fill.line;
    end
  end

  assign tag_match    = (tag_mem[idx_q] == tag_q);
  assign bus_readdata = data_mem[idx_q][word_q];

  // en_q keeps a freshly raised request from hitting on a stale address
  assign cache_hit  = en_q && valid[idx_q] && tag_match && !flush_busy;
  assign cache_miss = bus_en && !cache_hit;
  assign bus_wait   = bus_en && !cache_hit;

  assign miss_req  = bus_en && en_q && !cache_hit && !flush_busy && !fill.we;
  assign miss_addr = {addr_q[31:idx_lsb], {idx_lsb{1'b0}}};

endmodule

// ==== icache_pkg.sv ====
// shared bus and fill structs plus FSM encodings
// line width follows the settings header
`include "icache_settings.svh"

package icache_pkg;

  // requester side of the APB
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // slave side of the APB
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  // one line write into the cache arrays
  typedef struct packed {
    logic                                        we;
    logic [`ICACHE_LOG2_DEPTH-1:0]               index;
    logic [`ICACHE_TAG_BITS-1:0]                 tag;
    logic [(1 << `ICACHE_LOG2_LINE_WORDS)-1:0][31:0] line;
  } fill_t;

  typedef enum logic [1:0] {
    refill_idle,
    refill_setup,
    refill_access,
    refill_write
  } refill_state_e;

  typedef enum logic [1:0] {
    owner_none,
    owner_refill,
    owner_host
  } arb_owner_e;

endpackage

// ==== icache_settings.svh ====
// cache geometry and backing memory size, one configuration only
// tag width assumes a 32-bit byte address with word aligned fetches
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// 16 lines
`define ICACHE_LOG2_DEPTH 4

// 4 words of 32 bits per line
`define ICACHE_LOG2_LINE_WORDS 2

// address bits above index, word offset and byte offset
`define ICACHE_TAG_BITS (32 - `ICACHE_LOG2_DEPTH - `ICACHE_LOG2_LINE_WORDS - 2)

// backing memory of 1024 words
`define MEM_LOG2_WORDS 10

`endif
